// File: src/lrelu_pkg.sv
`default_nettype none

package lrelu_pkg;

  // lane and coefficient geometry
  localparam int UNITS        = 4;
  localparam int COEF_DEPTH   = 4;
  localparam int COEF_AW      = $clog2(COEF_DEPTH);
  localparam int FRAC_BITS    = 8;    // q8.8 scale words
  localparam int LRELU_ALPHA  = 26;   // about 0.1 in steps of 1/256
  localparam int PIPE_LATENCY = 3;    // s_valid to m_valid

  // signed 8-bit output range
  localparam int OUT_MAX = 127;
  localparam int OUT_MIN = -128;

  typedef logic signed [15:0] lane_word_t;
  typedef lane_word_t [UNITS-1:0] lane_vec_t;

  typedef logic signed [15:0] coef_t;

  typedef logic signed [23:0] mac_t;  // scaled, offset and sloped value
  typedef mac_t [UNITS-1:0] mac_vec_t;

  typedef logic signed [7:0] out_word_t;
  typedef out_word_t [UNITS-1:0] out_vec_t;

  typedef struct packed {
    logic is_lrelu;
    logic is_max;   // for the max-pool stage downstream
  } beat_user_t;

  typedef struct packed {
    logic is_max;
  } out_user_t;

  typedef enum logic [1:0] {CFG_D, CFG_A, CFG_B} cfg_target_t;

  typedef struct packed {
    logic               we;
    cfg_target_t        target;
    logic [COEF_AW-1:0] addr;
    coef_t              data;
  } cfg_write_t;

  typedef struct packed {
    coef_t a;
    coef_t b;
  } coef_row_t;

endpackage

`default_nettype wire

// File: src/lrelu_config_loader.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_config_loader (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfg_restart,
  input  logic                  cfg_valid,
  input  lrelu_pkg::coef_t      cfg_data,
  output lrelu_pkg::cfg_write_t cfg_wr
);

  import lrelu_pkg::*;

  cfg_target_t        state;
  cfg_target_t        state_next;
  logic [COEF_AW-1:0] addr;
  logic [COEF_AW-1:0] addr_next;
  logic               last_addr;

  assign last_addr = (addr == COEF_AW'(COEF_DEPTH - 1));

  // word order is D, then A[0..n-1], then B[0..n-1], then back to D
  always_comb begin
    state_next = state;
    addr_next  = addr;
    case (state)
      CFG_D: begin
        state_next = CFG_A;   // D is a single word
        addr_next  = '0;
      end
      CFG_A, CFG_B: begin
        if (last_addr) begin
          state_next = (state == CFG_A) ? CFG_B : CFG_D;
          addr_next  = '0;
        end else begin
          addr_next = addr + 1'b1;
        end
      end
      default: begin
        state_next = CFG_D;
        addr_next  = '0;
      end
    endcase
  end

  // one step per config word
  always_ff @(posedge clk) begin
    if (!rst_n || cfg_restart) begin
      state <= CFG_D;
      addr  <= '0;
    end else if (cfg_valid) begin
      state <= state_next;
      addr  <= addr_next;
    end
  end

  // write goes out in the same cycle as the word
  always_comb begin
    cfg_wr.we     = cfg_valid;
    cfg_wr.target = state;
    cfg_wr.addr   = addr;
    cfg_wr.data   = cfg_data;
  end

endmodule

`default_nettype wire

// File: src/lrelu_coef_store.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_coef_store (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfg_restart,
  input  lrelu_pkg::cfg_write_t cfg_wr,
  input  logic                  s_valid,
  output lrelu_pkg::coef_row_t  coef_row,
  output lrelu_pkg::coef_t      d
);

  import lrelu_pkg::*;

  coef_t              a_mem [COEF_DEPTH];  // scale per row
  coef_t              b_mem [COEF_DEPTH];  // offset per row
  coef_t              d_q;
  logic [COEF_AW-1:0] rd_ptr;
  logic               rd_last;

  // decode write target
  always_ff @(posedge clk) begin
    if (cfg_wr.we) begin
      case (cfg_wr.target)
        CFG_D:   d_q <= cfg_wr.data;
        CFG_A:   a_mem[cfg_wr.addr] <= cfg_wr.data;
        CFG_B:   b_mem[cfg_wr.addr] <= cfg_wr.data;
        default: d_q <= d_q;
      endcase
    end
  end

  assign rd_last = (rd_ptr == COEF_AW'(COEF_DEPTH - 1));

  // cyclic read pointer, counts beats and not cycles
  always_ff @(posedge clk) begin
    if (!rst_n || cfg_restart) begin
      rd_ptr <= '0;
    end else if (s_valid) begin
      if (rd_last) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // row is combinational so it lines up with s_data
  always_comb begin
    coef_row.a = a_mem[rd_ptr];
    coef_row.b = b_mem[rd_ptr];
  end

  assign d = d_q;

endmodule

`default_nettype wire

// File: src/lrelu_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_datapath (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  s_valid,
  input  lrelu_pkg::lane_vec_t  s_data,
  input  lrelu_pkg::beat_user_t s_user,
  input  lrelu_pkg::coef_row_t  coef_row,
  output logic                  act_valid,
  output lrelu_pkg::mac_vec_t   act_data,
  output lrelu_pkg::out_user_t  act_user
);

  import lrelu_pkg::*;

  mac_vec_t   mac_next;
  mac_vec_t   mac_q;
  mac_vec_t   act_next;
  logic       mac_valid;
  beat_user_t mac_user;

  // stage 1 math, floor(x*a/256) + b
  always_comb begin
    lane_word_t         x;
    coef_t              a;
    coef_t              b;
    logic signed [31:0] prod;
    for (int i = 0; i < UNITS; i++) begin
      x = s_data[i];
      a = coef_row.a;
      b = coef_row.b;
      prod = x * a;
      mac_next[i] = mac_t'(prod >>> FRAC_BITS) + mac_t'(b);  // arithmetic shift floors
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mac_valid <= 1'b0;
    end else begin
      mac_valid <= s_valid;
    end
  end

  always_ff @(posedge clk) begin
    mac_q    <= mac_next;
    mac_user <= s_user;
  end

  // stage 2 math, leaky slope on negative lanes only
  always_comb begin
    mac_t               m;
    logic signed [31:0] sloped;
    for (int i = 0; i < UNITS; i++) begin
      m = mac_q[i];
      sloped = m * LRELU_ALPHA;
      if (mac_user.is_lrelu && (m < 0)) begin
        act_next[i] = mac_t'(sloped >>> FRAC_BITS);
      end else begin
        act_next[i] = m;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      act_valid <= 1'b0;
    end else begin
      act_valid <= mac_valid;
    end
  end

  always_ff @(posedge clk) begin
    act_data        <= act_next;
    act_user.is_max <= mac_user.is_max;  // is_lrelu is spent here
  end

endmodule

`default_nettype wire

// File: src/lrelu_requant.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_requant (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 act_valid,
  input  lrelu_pkg::mac_vec_t  act_data,
  input  lrelu_pkg::out_user_t act_user,
  input  lrelu_pkg::coef_t     d,
  output logic                 m_valid,
  output lrelu_pkg::out_vec_t  m_data,
  output lrelu_pkg::out_user_t m_user
);

  import lrelu_pkg::*;

  out_vec_t sat_next;

  // add d, then clamp to int8
  always_comb begin
    mac_t                     act;
    logic signed [$bits(mac_t):0] sum;  // one extra bit so the add can't wrap
    for (int i = 0; i < UNITS; i++) begin
      act = act_data[i];
      sum = act + d;
      if (sum > OUT_MAX) begin
        sat_next[i] = out_word_t'(OUT_MAX);
      end else if (sum < OUT_MIN) begin
        sat_next[i] = out_word_t'(OUT_MIN);
      end else begin
        sat_next[i] = out_word_t'(sum);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else begin
      m_valid <= act_valid;
    end
  end

  always_ff @(posedge clk) begin
    m_data <= sat_next;
    m_user <= act_user;
  end

endmodule

`default_nettype wire

// File: src/lrelu_engine.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_engine (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfg_restart,
  input  logic                  cfg_valid,
  input  lrelu_pkg::coef_t      cfg_data,
  input  logic                  s_valid,
  input  lrelu_pkg::lane_vec_t  s_data,
  input  lrelu_pkg::beat_user_t s_user,
  output logic                  m_valid,
  output lrelu_pkg::out_vec_t   m_data,
  output lrelu_pkg::out_user_t  m_user
);

  import lrelu_pkg::*;

  cfg_write_t cfg_wr;     // loader to store
  coef_row_t  coef_row;   // row for the current beat
  coef_t      d;
  logic       act_valid;  // datapath to requant
  mac_vec_t   act_data;
  out_user_t  act_user;

  lrelu_config_loader loader_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_restart (cfg_restart),
    .cfg_valid   (cfg_valid),
    .cfg_data    (cfg_data),
    .cfg_wr      (cfg_wr)
  );

  lrelu_coef_store store_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_restart (cfg_restart),
    .cfg_wr      (cfg_wr),
    .s_valid     (s_valid),
    .coef_row    (coef_row),
    .d           (d)
  );

  lrelu_datapath datapath_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_user    (s_user),
    .coef_row  (coef_row),
    .act_valid (act_valid),
    .act_data  (act_data),
    .act_user  (act_user)
  );

  lrelu_requant requant_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .act_valid (act_valid),
    .act_data  (act_data),
    .act_user  (act_user),
    .d         (d),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_user    (m_user)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 10;  // 20 ns clock
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // released on an edge, the DUT reset is synchronous
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/lrelu_engine_props.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_engine_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  s_valid,
  input logic                  m_valid,
  input lrelu_pkg::cfg_write_t cfg_wr
);

  import lrelu_pkg::*;

  // every output beat has an input beat PIPE_LATENCY edges back
  latency_p: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid |-> $past(s_valid, PIPE_LATENCY))
    else $error("m_valid without an input beat %0d cycles earlier", PIPE_LATENCY);

  reset_p: assert property (@(posedge clk) !rst_n |=> !m_valid)
    else $error("m_valid high during reset or right after it");

  // D is a single word, so its write always sits at address 0
  cfg_addr_p: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_wr.we && (cfg_wr.target == CFG_D) |-> (cfg_wr.addr == '0))
    else $error("config write to D with a nonzero address");

endmodule

`default_nettype wire

// File: tb/lrelu_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lrelu_engine_tb;

  import lrelu_pkg::*;

  // reset and idle, then linear, leaky, gaps, restart, sideband
  localparam int TEST_CYCLES = 20 + 60 + 50 + 340 + 100 + 130;
  localparam int RUN_LIMIT   = TEST_CYCLES * 2 + 200;

  logic        clk;
  logic        rst_n;
  logic        cfg_restart;
  logic        cfg_valid;
  coef_t       cfg_data;
  logic        s_valid;
  lane_vec_t   s_data;
  beat_user_t  s_user;
  logic        m_valid;
  out_vec_t    m_data;
  out_user_t   m_user;

  logic [31:0] lfsr_q;
  int          cyc;
  int          checks;
  int          errors;
  int          test_err;       // error count when the current test began
  int          beat_cnt;       // model row pointer
  coef_t       a_m [COEF_DEPTH];
  coef_t       b_m [COEF_DEPTH];
  coef_t       d_m;
  out_vec_t    exp_data_q [$];
  logic        exp_max_q [$];
  int          exp_cyc_q [$];  // cycle the beat was taken

  tb_clock clock_i (.clk(clk), .rst_n(rst_n));

  lrelu_engine dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_restart (cfg_restart),
    .cfg_valid   (cfg_valid),
    .cfg_data    (cfg_data),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .s_user      (s_user),
    .m_valid     (m_valid),
    .m_data      (m_data),
    .m_user      (m_user)
  );

  bind lrelu_engine lrelu_engine_props props_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .m_valid (m_valid),
    .cfg_wr  (cfg_wr)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int signed_bits(input int n);
    logic signed [31:0] v;
    v = take_bits(n);
    v = v <<< (32 - n);
    return v >>> (32 - n);  // sign extend
  endfunction

  function automatic longint floor_div256(input longint v);
    longint q;
    q = v / 256;
    if ((v < 0) && (v % 256 != 0)) begin
      q = q - 1;  // division truncates toward zero
    end
    return q;
  endfunction

  function automatic out_vec_t model_lanes(input lane_vec_t x, input logic lrelu,
                                           input coef_t a, input coef_t b, input coef_t d);
    out_vec_t y;
    longint   mac;
    longint   act;
    longint   sum;
    for (int j = 0; j < UNITS; j++) begin
      mac = floor_div256(longint'(x[j]) * longint'(a)) + longint'(b);
      act = (lrelu && mac < 0) ? floor_div256(mac * LRELU_ALPHA) : mac;
      sum = act + longint'(d);
      if (sum > 127) sum = 127;
      if (sum < -128) sum = -128;
      y[j] = out_word_t'(sum);
    end
    return y;
  endfunction

  // outputs checked on pre-edge values, inputs taken as the DUT takes them
  always @(posedge clk) begin : monitor
    out_vec_t exp_d;
    logic     exp_max;
    int       exp_cyc;
    cyc <= cyc + 1;
    if (m_valid === 1'b1) begin
      checks++;
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("[ERROR] %0t: m_valid high with no beat in flight", $time);
      end else begin
        exp_d   = exp_data_q.pop_front();
        exp_max = exp_max_q.pop_front();
        exp_cyc = exp_cyc_q.pop_front();
        if (m_data !== exp_d) begin
          errors++;
          $display("[ERROR] %0t: m_data %h, expected %h", $time, m_data, exp_d);
        end
        if (m_user.is_max !== exp_max) begin
          errors++;
          $display("[ERROR] %0t: is_max %b, expected %b", $time, m_user.is_max, exp_max);
        end
        if (cyc - exp_cyc != PIPE_LATENCY) begin
          errors++;
          $display("[ERROR] %0t: result after %0d cycles, expected %0d", $time,
                   cyc - exp_cyc, PIPE_LATENCY);
        end
      end
    end
    if (!rst_n || cfg_restart) begin
      beat_cnt = 0;
    end else if (s_valid) begin
      exp_data_q.push_back(model_lanes(s_data, s_user.is_lrelu, a_m[beat_cnt],
                                       b_m[beat_cnt], d_m));
      exp_max_q.push_back(s_user.is_max);
      exp_cyc_q.push_back(cyc);
      beat_cnt = (beat_cnt + 1) % COEF_DEPTH;
    end
  end

  always @(posedge clk) begin
    if (cyc >= RUN_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  // D, then A rows, then B rows, in loader order
  task automatic load_coefs;
    coef_t words [2*COEF_DEPTH+1];
    d_m = coef_t'(signed_bits(6));
    words[0] = d_m;
    for (int i = 0; i < COEF_DEPTH; i++) begin
      a_m[i] = coef_t'(signed_bits(9));  // about -1.0 to 1.0
      words[1+i] = a_m[i];
    end
    for (int i = 0; i < COEF_DEPTH; i++) begin
      b_m[i] = coef_t'(signed_bits(8));
      words[1+COEF_DEPTH+i] = b_m[i];
    end
    foreach (words[i]) begin
      @(posedge clk);
      cfg_valid <= 1'b1;
      cfg_data  <= words[i];
    end
    @(posedge clk);
    cfg_valid <= 1'b0;
  endtask

  task automatic restart_pulse;
    @(posedge clk);
    cfg_restart <= 1'b1;
    @(posedge clk);
    cfg_restart <= 1'b0;
  endtask

  task automatic send_beats(input int n, input bit rand_lrelu, input int gap_bits);
    lane_vec_t  x;
    beat_user_t u;
    int         gap;
    for (int i = 0; i < n; i++) begin
      gap = int'(take_bits(gap_bits));
      repeat (gap) begin
        @(posedge clk);
        s_valid <= 1'b0;
      end
      for (int j = 0; j < UNITS; j++) begin
        x[j] = lane_word_t'(signed_bits(9));
      end
      u.is_lrelu = 1'b0;
      if (rand_lrelu) begin
        u.is_lrelu = take_bits(1) != 0;
      end
      u.is_max = take_bits(1) != 0;
      @(posedge clk);
      s_valid <= 1'b1;
      s_data  <= x;
      s_user  <= u;
    end
    @(posedge clk);
    s_valid <= 1'b0;
  endtask

  task automatic drain;
    repeat (2) @(posedge clk);
    while (exp_data_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);  // stray outputs would show here
  endtask

  task automatic end_test(input string name);
    if (errors == test_err) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - test_err);
    end
    test_err = errors;
  endtask

  initial begin
    lfsr_q   = 32'hfc53b01f;
    cyc      = 0;
    checks   = 0;
    errors   = 0;
    test_err = 0;
    beat_cnt = 0;
    cfg_restart <= 1'b0;
    cfg_valid   <= 1'b0;
    cfg_data    <= '0;
    s_valid     <= 1'b0;
    s_data      <= '0;
    s_user      <= '0;
    wait (rst_n === 1'b1);
    repeat (4) @(posedge clk);  // m_valid has to stay low here
    load_coefs();
    send_beats(40, 1'b0, 0);
    drain();
    end_test("linear path");
    send_beats(40, 1'b1, 0);
    drain();
    end_test("leaky path");
    send_beats(40, 1'b1, 3);
    drain();
    end_test("cyclic rows with gaps");
    restart_pulse();
    repeat (3) begin  // half a load, dropped by the next restart
      @(posedge clk);
      cfg_valid <= 1'b1;
      cfg_data  <= coef_t'(signed_bits(16));
    end
    @(posedge clk);
    cfg_valid <= 1'b0;
    for (int k = 0; k < 3; k++) begin
      restart_pulse();
      load_coefs();
      send_beats(5 + k, 1'b1, 1);
      drain();
    end
    end_test("restart");
    send_beats(30, 1'b1, 2);
    drain();
    end_test("sideband and latency");
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/lrelu_pkg.sv
src/lrelu_config_loader.sv
src/lrelu_coef_store.sv
src/lrelu_datapath.sv
src/lrelu_requant.sv
src/lrelu_engine.sv
tb/tb_clock.sv
tb/lrelu_engine_props.sv
tb/lrelu_engine_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and grep the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lrelu_engine_tb \
  -f build.f -o lrelu_sim > build.log 2>&1 \
  || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/lrelu_sim 2>&1 | tee sim.log

grep -qx "Everything OK" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
